// ==== common/sched_pkg.sv ====
/*
 * shared definitions for the issue slice
 * widths, commit and group id types, opcode and FSM state enums,
 * and the age compare used by the selector
 * referenced by scoped names only
 */
`default_nettype none

package sched_pkg;

  // commit id width, wrap bit included
  localparam int CMT_ID_W = 5;
  // slots per dispatch bundle
  localparam int DISP_SIZE = 4;
  localparam int TAG_W = 4;

  typedef struct packed {
    logic                wrap;
    logic [CMT_ID_W-2:0] idx;
  } cmt_id_t;

  // one-hot slot position in the bundle
  typedef logic [DISP_SIZE-1:0] grp_id_t;

  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_MUL
  } op_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUSY,
    S_DONE
  } exec_state_t;

  // true when (id0, grp0) was allocated before (id1, grp1)
  function automatic logic id0_is_older_than_id1(input cmt_id_t id0, input grp_id_t grp0,
                                                 input cmt_id_t id1, input grp_id_t grp1);
    // same bundle, lower slot first
    if (id0 == id1) return grp0 < grp1;
    // same lap of the counter
    if (id0.wrap == id1.wrap) return id0.idx < id1.idx;
    // id1 has wrapped past id0
    return id0.idx > id1.idx;
  endfunction

endpackage

`default_nettype wire

// ==== hw/sched/bit_multiple_age_min.sv ====
/*
 * oldest-entry picker for the scheduler
 * purely combinational linear scan over the valid entries,
 * ordering by commit id with wrap and then by group id
 */
`default_nettype none

module bit_multiple_age_min #(
  parameter int WORDS = 4
) (
  input  wire logic [WORDS-1:0]         i_valids,
  input  wire sched_pkg::cmt_id_t       i_cmt_id [WORDS],
  input  wire sched_pkg::grp_id_t       i_grp_id [WORDS],
  output logic                          o_valid,
  output logic [$clog2(WORDS)-1:0]      o_min_idx
);

  // running best candidate of the scan
  logic [$clog2(WORDS)-1:0] w_best_idx;
  logic                     w_best_valid;
  sched_pkg::cmt_id_t       w_best_cmt;
  sched_pkg::grp_id_t       w_best_grp;

  always_comb begin
    w_best_idx   = '0;
    w_best_valid = 1'b0;
    w_best_cmt   = i_cmt_id[0];
    w_best_grp   = i_grp_id[0];
    for (int i = 0; i < WORDS; i++) begin
      // first valid entry, or one older than the current best
      if (i_valids[i] && (!w_best_valid ||
          sched_pkg::id0_is_older_than_id1(i_cmt_id[i], i_grp_id[i],
                                           w_best_cmt, w_best_grp))) begin
        w_best_idx   = $clog2(WORDS)'(i);
        w_best_valid = 1'b1;
        w_best_cmt   = i_cmt_id[i];
        w_best_grp   = i_grp_id[i];
      end
    end
  end

  assign o_valid   = w_best_valid;
  assign o_min_idx = w_best_idx;

  // two requesting entries never carry the same age
  always_comb begin
    for (int i = 0; i < WORDS; i++) begin
      for (int j = i + 1; j < WORDS; j++) begin
        if (i_valids[i] && i_valids[j])
          assert ({i_cmt_id[i], i_grp_id[i]} != {i_cmt_id[j], i_grp_id[j]})
            else $error("two requesting entries share one commit and group id");
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/sched/sched_entries.sv ====
/*
 * scheduler entry storage
 * allocates the lowest free slot, readies pending entries on a tag
 * wakeup and frees the entry taken by the execution unit
 */
`default_nettype none

module sched_entries #(
  parameter int WORDS  = 4,
  parameter int DATA_W = 16
) (
  input  wire logic                          i_clk,
  input  wire logic                          i_arst_n,
  input  wire logic                          i_wr,
  input  wire sched_pkg::op_t                i_op,
  input  wire logic [DATA_W-1:0]             i_a,
  input  wire logic [DATA_W-1:0]             i_b,
  input  wire logic [sched_pkg::TAG_W-1:0]   i_tag,
  input  wire logic                          i_rdy,
  input  wire sched_pkg::cmt_id_t            i_cmt_id,
  input  wire sched_pkg::grp_id_t            i_grp_id,
  input  wire logic                          i_wake_valid,
  input  wire logic [sched_pkg::TAG_W-1:0]   i_wake_tag,
  input  wire logic                          i_take,
  input  wire logic [$clog2(WORDS)-1:0]      i_take_idx,
  output logic                               o_full,
  output logic [WORDS-1:0]                   o_ready_vec,
  output sched_pkg::cmt_id_t                 o_cmt_id [WORDS],
  output sched_pkg::grp_id_t                 o_grp_id [WORDS],
  output sched_pkg::op_t                     o_sel_op,
  output logic [DATA_W-1:0]                  o_sel_a,
  output logic [DATA_W-1:0]                  o_sel_b
);

  logic [WORDS-1:0]              r_valid;
  logic [WORDS-1:0]              r_ready;
  sched_pkg::op_t                r_op     [WORDS];
  logic [DATA_W-1:0]             r_a      [WORDS];
  logic [DATA_W-1:0]             r_b      [WORDS];
  logic [sched_pkg::TAG_W-1:0]   r_tag    [WORDS];
  sched_pkg::cmt_id_t            r_cmt_id [WORDS];
  sched_pkg::grp_id_t            r_grp_id [WORDS];
  logic [$clog2(WORDS)-1:0]      w_free_idx;
  logic                          w_wr_rdy;

  // scan downward so the lowest free slot wins
  always_comb begin
    w_free_idx = '0;
    for (int i = WORDS - 1; i >= 0; i--) begin
      if (!r_valid[i]) w_free_idx = $clog2(WORDS)'(i);
    end
  end

  // wakeup in the write cycle also catches the new entry
  assign w_wr_rdy = i_rdy || (i_wake_valid && (i_wake_tag == i_tag));

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_valid <= '0;
      r_ready <= '0;
    end else begin
      for (int i = 0; i < WORDS; i++) begin
        if (i_wake_valid && r_valid[i] && (r_tag[i] == i_wake_tag)) r_ready[i] <= 1'b1;
      end
      // taken slot is valid, so never the free slot below
      if (i_take) r_valid[i_take_idx] <= 1'b0;
      if (i_wr) begin
        r_valid[w_free_idx] <= 1'b1;
        r_ready[w_free_idx] <= w_wr_rdy;
      end
    end
  end

  // payload only
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_op[w_free_idx]     <= i_op;
      r_a[w_free_idx]      <= i_a;
      r_b[w_free_idx]      <= i_b;
      r_tag[w_free_idx]    <= i_tag;
      r_cmt_id[w_free_idx] <= i_cmt_id;
      r_grp_id[w_free_idx] <= i_grp_id;
    end
  end

  assign o_full      = &r_valid;
  assign o_ready_vec = r_valid & r_ready;
  assign o_cmt_id    = r_cmt_id;
  assign o_grp_id    = r_grp_id;
  assign o_sel_op    = r_op[i_take_idx];
  assign o_sel_a     = r_a[i_take_idx];
  assign o_sel_b     = r_b[i_take_idx];

  // selector and FSM must only take a live, woken entry
  a_take_ready: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_take |-> o_ready_vec[i_take_idx]);
  // dispatch handshake at the top must stall on full
  a_no_wr_full: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_wr |-> !o_full);

endmodule

`default_nettype wire

// ==== hw/sched/cmt_id_alloc.sv ====
/*
 * commit and group id allocator
 * one commit id per dispatch bundle, one-hot group id per slot;
 * advances on every dispatch transfer
 */
`default_nettype none

module cmt_id_alloc (
  input  wire logic           i_clk,
  input  wire logic           i_arst_n,
  input  wire logic           i_fire,
  input  wire logic           i_last,
  output sched_pkg::cmt_id_t  o_cmt_id,
  output sched_pkg::grp_id_t  o_grp_id
);

  sched_pkg::cmt_id_t r_cmt_id;
  sched_pkg::grp_id_t r_grp_id;
  logic               w_bundle_end;

  // bundle closes on an explicit last or on its final slot
  assign w_bundle_end = i_last || r_grp_id[sched_pkg::DISP_SIZE-1];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_cmt_id <= '0;
      r_grp_id <= sched_pkg::grp_id_t'(1);
    end else if (i_fire) begin
      if (w_bundle_end) begin
        // carry out of idx flips the wrap bit
        r_cmt_id <= sched_pkg::cmt_id_t'(r_cmt_id + 1'b1);
        r_grp_id <= sched_pkg::grp_id_t'(1);
      end else begin
        r_grp_id <= r_grp_id << 1;
      end
    end
  end

  assign o_cmt_id = r_cmt_id;
  assign o_grp_id = r_grp_id;

endmodule

`default_nettype wire

// ==== hw/exec/exec_timer.sv ====
/*
 * step timer for the execution unit
 * loads 1 or DATA_W steps and counts down once per cycle;
 * o_last pulses once after the final step has run
 */
`default_nettype none

module exec_timer #(
  parameter int DATA_W = 16
) (
  input  wire logic i_clk,
  input  wire logic i_arst_n,
  input  wire logic i_load,
  input  wire logic i_long,
  output logic      o_last
);

  localparam int CNT_W = $clog2(DATA_W + 1);

  // remaining steps
  logic [CNT_W-1:0] r_cnt;
  // set while a count is live
  logic             r_run;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_cnt <= '0;
      r_run <= 1'b0;
    end else if (i_load) begin
      r_cnt <= i_long ? CNT_W'(DATA_W) : CNT_W'(1);
      r_run <= 1'b1;
    end else begin
      if (r_cnt != '0) r_cnt <= r_cnt - 1'b1;
      if (o_last) r_run <= 1'b0;
    end
  end

  assign o_last = r_run && (r_cnt == '0);

endmodule

`default_nettype wire

// ==== hw/exec/exec_alu.sv ====
/*
 * execution datapath
 * latches operands on load, then one step per cycle:
 * single-step ops recompute, MUL runs a shift-add loop
 */
`default_nettype none

module exec_alu #(
  parameter int DATA_W = 16
) (
  input  wire logic              i_clk,
  input  wire logic              i_arst_n,
  input  wire logic              i_load,
  input  wire sched_pkg::op_t    i_op,
  input  wire logic [DATA_W-1:0] i_a,
  input  wire logic [DATA_W-1:0] i_b,
  output logic [DATA_W-1:0]      o_data
);

  sched_pkg::op_t    r_op;
  logic [DATA_W-1:0] r_a;
  logic [DATA_W-1:0] r_b;
  logic [DATA_W-1:0] r_acc;

  // multiplier bits shift out, multiplicand shifts up
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_a <= i_a;
      r_b <= i_b;
    end else if (r_op == sched_pkg::OP_MUL) begin
      r_a <= r_a >> 1;
      r_b <= r_b << 1;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_op  <= sched_pkg::OP_ADD;
      r_acc <= '0;
    end else if (i_load) begin
      r_op  <= i_op;
      r_acc <= '0;
    end else begin
      case (r_op)
        sched_pkg::OP_ADD: r_acc <= r_a + r_b;
        sched_pkg::OP_SUB: r_acc <= r_a - r_b;
        sched_pkg::OP_XOR: r_acc <= r_a ^ r_b;
        // once r_a is drained the sum stays put
        sched_pkg::OP_MUL: if (r_a[0]) r_acc <= r_acc + r_b;
        default:           r_acc <= r_acc;
      endcase
    end
  end

  assign o_data = r_acc;

endmodule

`default_nettype wire

// ==== hw/exec/exec_fsm.sv ====
/*
 * execution control
 * takes the oldest ready entry when idle, waits for the step timer,
 * then holds the result ids until the consumer accepts
 */
`default_nettype none

module exec_fsm #(
  parameter int WORDS = 4
) (
  input  wire logic                i_clk,
  input  wire logic                i_arst_n,
  input  wire logic                i_sel_valid,
  input  wire logic                i_timer_last,
  input  wire logic                i_res_ready,
  input  wire sched_pkg::cmt_id_t  i_sel_cmt_id,
  input  wire sched_pkg::grp_id_t  i_sel_grp_id,
  output logic                     o_take,
  output logic                     o_res_valid,
  output sched_pkg::cmt_id_t       o_res_cmt_id,
  output sched_pkg::grp_id_t       o_res_grp_id
);

  sched_pkg::exec_state_t r_state;
  sched_pkg::exec_state_t w_state_next;

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      sched_pkg::S_IDLE: if (i_sel_valid) w_state_next = sched_pkg::S_BUSY;
      sched_pkg::S_BUSY: if (i_timer_last) w_state_next = sched_pkg::S_DONE;
      sched_pkg::S_DONE: if (i_res_ready) w_state_next = sched_pkg::S_IDLE;
      default:           w_state_next = sched_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) r_state <= sched_pkg::S_IDLE;
    else           r_state <= w_state_next;
  end

  // ids of the entry in flight
  always_ff @(posedge i_clk) begin
    if (o_take) begin
      o_res_cmt_id <= i_sel_cmt_id;
      o_res_grp_id <= i_sel_grp_id;
    end
  end

  assign o_take      = (r_state == sched_pkg::S_IDLE) && i_sel_valid;
  assign o_res_valid = (r_state == sched_pkg::S_DONE);

  // stored entries plus the one in flight must fit half the id range
  initial begin
    assert (WORDS + 1 <= (1 << (sched_pkg::CMT_ID_W - 1)))
      else $error("too many entries for the commit id width");
  end

  // the step timer only finishes an op in flight
  a_last_busy: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_timer_last |-> (r_state == sched_pkg::S_BUSY));
  // result ids held while back-pressured
  a_res_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_res_valid && !i_res_ready |=>
      o_res_valid && $stable(o_res_cmt_id) && $stable(o_res_grp_id));

endmodule

`default_nettype wire

// ==== hw/sched_top.sv ====
/*
 * issue slice top level
 * dispatch into a small scheduler, oldest-ready selection by age,
 * one execution unit with a held result on a valid/ready port
 */
`default_nettype none

module sched_top #(
  parameter int WORDS  = 4,
  parameter int DATA_W = 16
) (
  input  wire logic                        i_clk,
  input  wire logic                        i_arst_n,
  // dispatch
  input  wire logic                        i_dsp_valid,
  output logic                             o_dsp_ready,
  input  wire sched_pkg::op_t              i_dsp_op,
  input  wire logic [DATA_W-1:0]           i_dsp_a,
  input  wire logic [DATA_W-1:0]           i_dsp_b,
  input  wire logic [sched_pkg::TAG_W-1:0] i_dsp_tag,
  input  wire logic                        i_dsp_rdy,
  input  wire logic                        i_dsp_last,
  // wakeup broadcast
  input  wire logic                        i_wake_valid,
  input  wire logic [sched_pkg::TAG_W-1:0] i_wake_tag,
  // result
  output logic                             o_res_valid,
  input  wire logic                        i_res_ready,
  output logic [DATA_W-1:0]                o_res_data,
  output sched_pkg::cmt_id_t               o_res_cmt_id,
  output sched_pkg::grp_id_t               o_res_grp_id
);

  logic                     w_fire;
  logic                     w_full;
  sched_pkg::cmt_id_t       w_cmt_id;
  sched_pkg::grp_id_t       w_grp_id;
  logic [WORDS-1:0]         w_ready_vec;
  sched_pkg::cmt_id_t       w_ent_cmt_id [WORDS];
  sched_pkg::grp_id_t       w_ent_grp_id [WORDS];
  logic                     w_sel_valid;
  logic [$clog2(WORDS)-1:0] w_sel_idx;
  logic                     w_take;
  logic                     w_timer_last;
  sched_pkg::op_t           w_sel_op;
  logic [DATA_W-1:0]        w_sel_a;
  logic [DATA_W-1:0]        w_sel_b;

  assign o_dsp_ready = !w_full;
  assign w_fire      = i_dsp_valid && o_dsp_ready;

  cmt_id_alloc u_cmt_id_alloc (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_fire   (w_fire),
    .i_last   (i_dsp_last),
    .o_cmt_id (w_cmt_id),
    .o_grp_id (w_grp_id)
  );

  sched_entries #(.WORDS(WORDS), .DATA_W(DATA_W)) u_sched_entries (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_wr         (w_fire),
    .i_op         (i_dsp_op),
    .i_a          (i_dsp_a),
    .i_b          (i_dsp_b),
    .i_tag        (i_dsp_tag),
    .i_rdy        (i_dsp_rdy),
    .i_cmt_id     (w_cmt_id),
    .i_grp_id     (w_grp_id),
    .i_wake_valid (i_wake_valid),
    .i_wake_tag   (i_wake_tag),
    .i_take       (w_take),
    .i_take_idx   (w_sel_idx),
    .o_full       (w_full),
    .o_ready_vec  (w_ready_vec),
    .o_cmt_id     (w_ent_cmt_id),
    .o_grp_id     (w_ent_grp_id),
    .o_sel_op     (w_sel_op),
    .o_sel_a      (w_sel_a),
    .o_sel_b      (w_sel_b)
  );

  bit_multiple_age_min #(.WORDS(WORDS)) u_age_min (
    .i_valids  (w_ready_vec),
    .i_cmt_id  (w_ent_cmt_id),
    .i_grp_id  (w_ent_grp_id),
    .o_valid   (w_sel_valid),
    .o_min_idx (w_sel_idx)
  );

  exec_fsm #(.WORDS(WORDS)) u_exec_fsm (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_sel_valid  (w_sel_valid),
    .i_timer_last (w_timer_last),
    .i_res_ready  (i_res_ready),
    .i_sel_cmt_id (w_ent_cmt_id[w_sel_idx]),
    .i_sel_grp_id (w_ent_grp_id[w_sel_idx]),
    .o_take       (w_take),
    .o_res_valid  (o_res_valid),
    .o_res_cmt_id (o_res_cmt_id),
    .o_res_grp_id (o_res_grp_id)
  );

  // MUL is the only multi-step op
  exec_timer #(.DATA_W(DATA_W)) u_exec_timer (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_load   (w_take),
    .i_long   (w_sel_op == sched_pkg::OP_MUL),
    .o_last   (w_timer_last)
  );

  exec_alu #(.DATA_W(DATA_W)) u_exec_alu (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_load   (w_take),
    .i_op     (w_sel_op),
    .i_a      (w_sel_a),
    .i_b      (w_sel_b),
    .o_data   (o_res_data)
  );

endmodule

`default_nettype wire

// ==== dv/tb_sched_top.sv ====
/*
 * self-checking testbench for the issue slice
 * a cycle model of allocator, entries and execution unit runs beside the DUT,
 * and every cycle its outputs are compared with the model's prediction
 * directed ops first, then LFSR driven dispatch, wakeup and back-pressure
 */
`default_nettype none

module tb_sched_top;

  localparam int WORDS      = 4;
  localparam int DATA_W     = 16;
  localparam int N_OPS      = 200;
  localparam int N_RAND     = N_OPS - 12;
  // worst-case MUL latency per op plus accept and wakeup slack
  localparam int MAX_CYCLES = N_OPS * (DATA_W + 1 + 16) + 2000;
  localparam int ITEM_W     = 2 + 2 * DATA_W + sched_pkg::TAG_W + 2;

  logic                        i_clk;
  logic                        i_arst_n;
  logic                        i_dsp_valid;
  logic                        o_dsp_ready;
  sched_pkg::op_t              i_dsp_op;
  logic [DATA_W-1:0]           i_dsp_a;
  logic [DATA_W-1:0]           i_dsp_b;
  logic [sched_pkg::TAG_W-1:0] i_dsp_tag;
  logic                        i_dsp_rdy;
  logic                        i_dsp_last;
  logic                        i_wake_valid;
  logic [sched_pkg::TAG_W-1:0] i_wake_tag;
  logic                        o_res_valid;
  logic                        i_res_ready;
  logic [DATA_W-1:0]           o_res_data;
  sched_pkg::cmt_id_t          o_res_cmt_id;
  sched_pkg::grp_id_t          o_res_grp_id;

  // stimulus queue, one packed dispatch per item
  logic [ITEM_W-1:0]              dsp_q [$];
  logic [31:0]                    lfsr = 32'h68d2_b4f4;
  int                             ops_pushed = 0;
  int                             res_cnt = 0;
  int                             cyc_cnt = 0;
  logic                           saw_wrap = 1'b0;

  // reference model state
  logic [WORDS-1:0]               ent_vld;
  logic [WORDS-1:0]               ent_rdy;
  sched_pkg::op_t                 ent_op  [WORDS];
  logic [DATA_W-1:0]              ent_a   [WORDS];
  logic [DATA_W-1:0]              ent_b   [WORDS];
  logic [sched_pkg::TAG_W-1:0]    ent_tag [WORDS];
  logic [sched_pkg::CMT_ID_W-1:0] ent_cmt [WORDS];
  logic [sched_pkg::DISP_SIZE-1:0] ent_grp [WORDS];
  logic [sched_pkg::CMT_ID_W-1:0] alloc_cmt;
  logic [sched_pkg::DISP_SIZE-1:0] alloc_grp;
  sched_pkg::exec_state_t         ref_state;
  logic [DATA_W-1:0]              exp_data;
  logic [sched_pkg::CMT_ID_W-1:0] exp_cmt;
  logic [sched_pkg::DISP_SIZE-1:0] exp_grp;
  int                             done_at;
  int                             edge_cnt;

  sched_top #(.WORDS(WORDS), .DATA_W(DATA_W)) u_sched_top (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_dsp_valid  (i_dsp_valid),
    .o_dsp_ready  (o_dsp_ready),
    .i_dsp_op     (i_dsp_op),
    .i_dsp_a      (i_dsp_a),
    .i_dsp_b      (i_dsp_b),
    .i_dsp_tag    (i_dsp_tag),
    .i_dsp_rdy    (i_dsp_rdy),
    .i_dsp_last   (i_dsp_last),
    .i_wake_valid (i_wake_valid),
    .i_wake_tag   (i_wake_tag),
    .o_res_valid  (o_res_valid),
    .i_res_ready  (i_res_ready),
    .o_res_data   (o_res_data),
    .o_res_cmt_id (o_res_cmt_id),
    .o_res_grp_id (o_res_grp_id)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // age rule: id1 less than half the id range ahead of id0 means id0 is older
  function automatic logic ref_older(input logic [sched_pkg::CMT_ID_W-1:0] c0,
                                     input logic [sched_pkg::DISP_SIZE-1:0] g0,
                                     input logic [sched_pkg::CMT_ID_W-1:0] c1,
                                     input logic [sched_pkg::DISP_SIZE-1:0] g1);
    logic [sched_pkg::CMT_ID_W-1:0] diff;
    if (c0 == c1) return g0 < g1;
    diff = c1 - c0;
    return !diff[sched_pkg::CMT_ID_W-1];
  endfunction

  // oldest ready model entry, -1 when none
  function automatic int ref_pick();
    int best;
    best = -1;
    for (int i = 0; i < WORDS; i++) begin
      if (ent_vld[i] && ent_rdy[i] && (best < 0 ||
          ref_older(ent_cmt[i], ent_grp[i], ent_cmt[best], ent_grp[best]))) best = i;
    end
    return best;
  endfunction

  function automatic logic [DATA_W-1:0] ref_calc(input sched_pkg::op_t op,
                                                 input logic [DATA_W-1:0] a,
                                                 input logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] prod;
    prod = (2*DATA_W)'(a) * (2*DATA_W)'(b);
    case (op)
      sched_pkg::OP_ADD: return a + b;
      sched_pkg::OP_SUB: return a - b;
      sched_pkg::OP_XOR: return a ^ b;
      default:           return prod[DATA_W-1:0];
    endcase
  endfunction

  task automatic push_op(input sched_pkg::op_t op, input logic [DATA_W-1:0] a,
                         input logic [DATA_W-1:0] b, input logic [sched_pkg::TAG_W-1:0] tag,
                         input logic rdy, input logic last);
    dsp_q.push_back({op, a, b, tag, rdy, last});
    ops_pushed++;
  endtask

  // one clock: next dispatch once the held one transferred, then wakeup and accept
  task automatic tick(input logic wv, input logic [sched_pkg::TAG_W-1:0] wt, input logic rr);
    logic [ITEM_W-1:0] item;
    logic              fired;
    @(negedge i_clk);
    fired = i_dsp_valid && o_dsp_ready;
    @(posedge i_clk);
    #1;
    if (fired || !i_dsp_valid) begin
      if (dsp_q.size() > 0) begin
        item        = dsp_q.pop_front();
        i_dsp_op    = sched_pkg::op_t'(item[ITEM_W-1 -: 2]);
        i_dsp_a     = item[ITEM_W-3 -: DATA_W];
        i_dsp_b     = item[ITEM_W-3-DATA_W -: DATA_W];
        i_dsp_tag   = item[2 +: sched_pkg::TAG_W];
        i_dsp_rdy   = item[1];
        i_dsp_last  = item[0];
        i_dsp_valid = 1'b1;
      end else begin
        i_dsp_valid = 1'b0;
      end
    end
    i_wake_valid = wv;
    i_wake_tag   = wt;
    i_res_ready  = rr;
  endtask

  // rotating wakeups until queue, entries and execution unit are empty
  task automatic drain();
    logic [sched_pkg::TAG_W-1:0] t;
    t = '0;
    while (dsp_q.size() != 0 || i_dsp_valid || ent_vld != '0 ||
           ref_state != sched_pkg::S_IDLE) begin
      tick(1'b1, t, 1'b1);
      t = t + 1'b1;
    end
  endtask

  // model and compare, sampled mid-cycle for the coming edge
  always @(negedge i_clk) begin
    int pick;
    int slot;
    if (!i_arst_n) begin
      ent_vld   = '0;
      ent_rdy   = '0;
      ref_state = sched_pkg::S_IDLE;
      alloc_cmt = '0;
      alloc_grp = 1;
      edge_cnt  = 0;
    end else begin
      check_eq("o_dsp_ready", 32'(o_dsp_ready), 32'($countones(ent_vld) != WORDS));
      check_eq("o_res_valid", 32'(o_res_valid), 32'(ref_state == sched_pkg::S_DONE));
      if (ref_state == sched_pkg::S_DONE) begin
        check_eq("o_res_data", 32'(o_res_data), 32'(exp_data));
        check_eq("o_res_cmt_id", 32'(o_res_cmt_id), 32'(exp_cmt));
        check_eq("o_res_grp_id", 32'(o_res_grp_id), 32'(exp_grp));
      end
      case (ref_state)
        sched_pkg::S_IDLE: begin
          pick = ref_pick();
          if (pick >= 0) begin
            exp_data      = ref_calc(ent_op[pick], ent_a[pick], ent_b[pick]);
            exp_cmt       = ent_cmt[pick];
            exp_grp       = ent_grp[pick];
            ent_vld[pick] = 1'b0;
            ref_state     = sched_pkg::S_BUSY;
            done_at = edge_cnt + ((ent_op[pick] == sched_pkg::OP_MUL) ? DATA_W + 1 : 2);
          end
        end
        sched_pkg::S_BUSY: if (edge_cnt == done_at) ref_state = sched_pkg::S_DONE;
        default: begin
          if (i_res_ready) begin
            ref_state = sched_pkg::S_IDLE;
            res_cnt++;
          end
        end
      endcase
      for (int i = 0; i < WORDS; i++) begin
        if (i_wake_valid && ent_vld[i] && ent_tag[i] == i_wake_tag) ent_rdy[i] = 1'b1;
      end
      if (i_dsp_valid && o_dsp_ready) begin
        slot = -1;
        for (int i = 0; i < WORDS; i++) begin
          if (!ent_vld[i] && slot < 0) slot = i;
        end
        ent_vld[slot] = 1'b1;
        ent_rdy[slot] = i_dsp_rdy || (i_wake_valid && i_wake_tag == i_dsp_tag);
        ent_op[slot]  = i_dsp_op;
        ent_a[slot]   = i_dsp_a;
        ent_b[slot]   = i_dsp_b;
        ent_tag[slot] = i_dsp_tag;
        ent_cmt[slot] = alloc_cmt;
        ent_grp[slot] = alloc_grp;
        // bundle closes on last or on its fourth slot
        if (i_dsp_last || alloc_grp[sched_pkg::DISP_SIZE-1]) begin
          alloc_cmt = alloc_cmt + 1'b1;
          alloc_grp = 1;
          if (alloc_cmt[sched_pkg::CMT_ID_W-2:0] == '0) saw_wrap = 1'b1;
        end else begin
          alloc_grp = alloc_grp << 1;
        end
      end
      edge_cnt++;
    end
  end

  always @(posedge i_clk) begin
    cyc_cnt++;
    if (cyc_cnt > MAX_CYCLES) abort_run("timeout: the DUT stopped producing results");
  end

  initial begin
    logic [31:0]    r;
    logic [31:0]    ra;
    logic [31:0]    rb;
    sched_pkg::op_t op;
    i_arst_n     = 1'b0;
    i_dsp_valid  = 1'b0;
    i_dsp_op     = sched_pkg::OP_ADD;
    i_dsp_a      = '0;
    i_dsp_b      = '0;
    i_dsp_tag    = '0;
    i_dsp_rdy    = 1'b0;
    i_dsp_last   = 1'b0;
    i_wake_valid = 1'b0;
    i_wake_tag   = '0;
    i_res_ready  = 1'b0;
    repeat (10) @(posedge i_clk);
    #1;
    i_arst_n = 1'b1;

    // single-step ops and MUL, all ready, bundles closed by slot count and by last
    push_op(sched_pkg::OP_ADD, 16'h1234, 16'h0f0f, 4'h0, 1'b1, 1'b0);
    push_op(sched_pkg::OP_SUB, 16'h0005, 16'h0009, 4'h0, 1'b1, 1'b0);
    push_op(sched_pkg::OP_XOR, 16'ha5a5, 16'h3c3c, 4'h0, 1'b1, 1'b0);
    push_op(sched_pkg::OP_MUL, 16'h00ff, 16'h0101, 4'h0, 1'b1, 1'b0);
    push_op(sched_pkg::OP_ADD, 16'hffff, 16'h0001, 4'h0, 1'b1, 1'b1);
    push_op(sched_pkg::OP_MUL, 16'hffff, 16'hffff, 4'h0, 1'b1, 1'b0);
    push_op(sched_pkg::OP_XOR, 16'h0000, 16'hffff, 4'h0, 1'b1, 1'b1);
    push_op(sched_pkg::OP_MUL, 16'h1234, 16'h5678, 4'h0, 1'b1, 1'b1);
    drain();

    // pending entry ignores a foreign tag
    push_op(sched_pkg::OP_ADD, 16'h0101, 16'h0202, 4'h3, 1'b0, 1'b1);
    repeat (6) tick(1'b1, 4'h4, 1'b1);
    tick(1'b1, 4'h3, 1'b1);
    drain();

    // younger entry wakes first while a MUL runs, older still issues first
    push_op(sched_pkg::OP_MUL, 16'h0123, 16'h0045, 4'h0, 1'b1, 1'b1);
    push_op(sched_pkg::OP_ADD, 16'h1111, 16'h2222, 4'h1, 1'b0, 1'b1);
    push_op(sched_pkg::OP_SUB, 16'h3333, 16'h0444, 4'h2, 1'b0, 1'b0);
    repeat (4) tick(1'b0, 4'h0, 1'b1);
    tick(1'b1, 4'h2, 1'b1);
    repeat (3) tick(1'b0, 4'h0, 1'b1);
    tick(1'b1, 4'h1, 1'b1);
    drain();

    // random ops, readiness, bundle ends, wakeups and back-pressure
    for (int n = 0; n < N_RAND; n++) begin
      r  = rand_bits(2);
      op = sched_pkg::op_t'(r[1:0]);
      ra = rand_bits(DATA_W);
      rb = rand_bits(DATA_W);
      r  = rand_bits(8);
      push_op(op, ra[DATA_W-1:0], rb[DATA_W-1:0], r[7:4], r[3:2] != 2'd0, r[1:0] == 2'd0);
    end
    while (dsp_q.size() != 0 || i_dsp_valid) begin
      r = rand_bits(6);
      tick(r[5], r[4:1], r[0]);
    end
    drain();
    tick(1'b0, 4'h0, 1'b1);

    if (res_cnt == ops_pushed && saw_wrap) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d results for %0d dispatched ops, commit id wrap seen %0d",
               res_cnt, ops_pushed, saw_wrap);
      $display("Test failures found");
      $fatal(1, "incomplete run");
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
common/sched_pkg.sv
hw/sched/bit_multiple_age_min.sv
hw/sched/sched_entries.sv
hw/sched/cmt_id_alloc.sv
hw/exec/exec_timer.sv
hw/exec/exec_alu.sv
hw/exec/exec_fsm.sv
hw/sched_top.sv
dv/tb_sched_top.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sched_top -f src.f -o tb_sched_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sched_top > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q 'All tests passed!' sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
